// ==== source/exec_pkg.sv ====
////////////////////////////////////////
// Execution slice definitions
// Widths, operation codes and unit selector shared by
// the issue stage, both execution units and the register file
////////////////////////////////////////

package exec_pkg;

    // Datapath sizes
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);
    localparam int SHAMT_W    = $clog2(XLEN);

    // Multiplier latency, acceptance edge to writeback edge
    localparam int MUL_STAGES = 3;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            op_t;

    // Execution unit selector
    typedef logic unit_t;
    localparam unit_t UNIT_ALU = 1'b0;
    localparam unit_t UNIT_MUL = 1'b1;

    ////////////////////////////////////////
    // ALU operation codes
    localparam op_t OP_ADD  = 4'd0;
    localparam op_t OP_SUB  = 4'd1;
    localparam op_t OP_AND  = 4'd2;
    localparam op_t OP_OR   = 4'd3;
    localparam op_t OP_XOR  = 4'd4;
    localparam op_t OP_SLL  = 4'd5;
    localparam op_t OP_SRL  = 4'd6;
    localparam op_t OP_SRA  = 4'd7;
    localparam op_t OP_SLT  = 4'd8;
    localparam op_t OP_SLTU = 4'd9;
    // rd takes the immediate
    localparam op_t OP_LI   = 4'd10;

    ////////////////////////////////////////
    // Multiplier operation codes
    // Low word of the product
    localparam op_t OP_MUL    = 4'd0;
    // High word, signed x signed
    localparam op_t OP_MULH   = 4'd1;
    // High word, signed x unsigned
    localparam op_t OP_MULHSU = 4'd2;
    // High word, unsigned x unsigned
    localparam op_t OP_MULHU  = 4'd3;

endpackage

// ==== source/issue_stage.sv ====
////////////////////////////////////////
// Issue stage
// Per-register scoreboard, stall decision and dispatch
// of register operands to the ALU or the multiplier
////////////////////////////////////////

`timescale 1ns/100ps

module issue_stage import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      issue_valid,
    input  unit_t     issue_unit,
    input  op_t       issue_op,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_addr,
    input  data_t     issue_imm,
    output logic      issue_ready,

    output reg_addr_t rf_rs1_addr,
    output reg_addr_t rf_rs2_addr,
    input  data_t     rf_rs1_data,
    input  data_t     rf_rs2_data,

    output logic      alu_start,
    output op_t       alu_op,
    output data_t     alu_rs1,
    output data_t     alu_rs2,
    output data_t     alu_imm,
    output reg_addr_t alu_rd,

    output logic      mul_start,
    output op_t       mul_op,
    output data_t     mul_rs1,
    output data_t     mul_rs2,
    output reg_addr_t mul_rd,

    input  logic      alu_wb_valid,
    input  reg_addr_t alu_wb_rd,
    input  logic      mul_wb_valid,
    input  reg_addr_t mul_wb_rd
);

    // One bit per register, set while a result is in flight
    logic [NUM_REGS-1:0] pending;
    logic                is_li;
    logic                hazard;
    logic                accept;

    ////////////////////////////////////////
    // Stall decision
    // LI has no source registers, so only rd matters
    assign is_li  = (issue_unit == UNIT_ALU) && (issue_op == OP_LI);
    assign hazard = pending[rd_addr] ||
                    (!is_li && (pending[rs1_addr] || pending[rs2_addr]));

    assign issue_ready = !hazard;
    assign accept      = issue_valid && issue_ready;

    // Operand read
    assign rf_rs1_addr = rs1_addr;
    assign rf_rs2_addr = rs2_addr;

    ////////////////////////////////////////
    // Dispatch
    // Units register on the acceptance edge, so the ALU result lands
    // one edge later and the multiplier result MUL_STAGES edges later
    assign alu_start = accept && (issue_unit == UNIT_ALU);
    assign alu_op    = issue_op;
    assign alu_rs1   = rf_rs1_data;
    assign alu_rs2   = rf_rs2_data;
    assign alu_imm   = issue_imm;
    assign alu_rd    = rd_addr;

    assign mul_start = accept && (issue_unit == UNIT_MUL);
    assign mul_op    = issue_op;
    assign mul_rs1   = rf_rs1_data;
    assign mul_rs2   = rf_rs2_data;
    assign mul_rd    = rd_addr;

    ////////////////////////////////////////
    // Scoreboard
    // x0 is never marked. A set and a clear of one register cannot
    // meet on the same edge since acceptance needs the bit clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin
                if (accept && (rd_addr == reg_addr_t'(i))) begin
                    pending[i] <= 1'b1;
                end else if ((alu_wb_valid && (alu_wb_rd == reg_addr_t'(i))) ||
                             (mul_wb_valid && (mul_wb_rd == reg_addr_t'(i)))) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/alu_unit.sv ====
////////////////////////////////////////
// Integer ALU
// RV32I register-register operations plus load-immediate,
// result registered together with its destination
////////////////////////////////////////

`timescale 1ns/100ps

module alu_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      alu_start,
    input  op_t       alu_op,
    input  data_t     alu_rs1,
    input  data_t     alu_rs2,
    input  data_t     alu_imm,
    input  reg_addr_t alu_rd,

    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output data_t     wb_data
);

    logic [SHAMT_W-1:0] shamt;
    data_t              result;

    // Upper bits of rs2 are ignored for shifts
    assign shamt = alu_rs2[SHAMT_W-1:0];

    ////////////////////////////////////////
    // Operation select
    always_comb begin
        case (alu_op)
            OP_ADD:  result = alu_rs1 + alu_rs2;
            OP_SUB:  result = alu_rs1 - alu_rs2;
            OP_AND:  result = alu_rs1 & alu_rs2;
            OP_OR:   result = alu_rs1 | alu_rs2;
            OP_XOR:  result = alu_rs1 ^ alu_rs2;
            OP_SLL:  result = alu_rs1 << shamt;
            OP_SRL:  result = alu_rs1 >> shamt;
            OP_SRA:  result = data_t'($signed(alu_rs1) >>> shamt);
            // Comparisons give 1 or 0
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(alu_rs1) < $signed(alu_rs2)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, alu_rs1 < alu_rs2};
            OP_LI:   result = alu_imm;
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Writeback register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_start;
        end
    end

    // Payload only moves on a start
    always_ff @(posedge clk) begin
        if (alu_start) begin
            wb_rd   <= alu_rd;
            wb_data <= result;
        end
    end

endmodule

// ==== source/mul_unit.sv ====
////////////////////////////////////////
// Pipelined multiplier
// 32x32 multiply over three stages returning the low or
// high word, one new operation accepted per cycle
////////////////////////////////////////

`timescale 1ns/100ps

module mul_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      mul_start,
    input  op_t       mul_op,
    input  data_t     mul_rs1,
    input  data_t     mul_rs2,
    input  reg_addr_t mul_rd,

    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output data_t     wb_data
);

    logic a_signed;
    logic b_signed;
    logic sel_high;

    logic signed [XLEN:0]     s1_a;
    logic signed [XLEN:0]     s1_b;
    logic                     s1_high;
    logic signed [2*XLEN+1:0] s2_prod;
    logic                     s2_high;

    // Valid and rd travel alongside the data stages
    logic [MUL_STAGES-1:0] valid_q;
    reg_addr_t             rd_q [MUL_STAGES];

    // Operand signedness and word select per op
    always_comb begin
        case (mul_op)
            OP_MUL:    {a_signed, b_signed, sel_high} = 3'b110;
            OP_MULH:   {a_signed, b_signed, sel_high} = 3'b111;
            OP_MULHSU: {a_signed, b_signed, sel_high} = 3'b101;
            OP_MULHU:  {a_signed, b_signed, sel_high} = 3'b001;
            default:   {a_signed, b_signed, sel_high} = 3'b000;
        endcase
    end

    ////////////////////////////////////////
    // Control pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_STAGES-2:0], mul_start};
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0] <= mul_rd;
        for (int k = 1; k < MUL_STAGES; k++) begin
            rd_q[k] <= rd_q[k-1];
        end
    end

    ////////////////////////////////////////
    // Data stages
    always_ff @(posedge clk) begin
        // Stage 1, extend to 33 bits
        if (mul_start) begin
            s1_a    <= {a_signed & mul_rs1[XLEN-1], mul_rs1};
            s1_b    <= {b_signed & mul_rs2[XLEN-1], mul_rs2};
            s1_high <= sel_high;
        end
        // Stage 2, full signed product
        if (valid_q[0]) begin
            s2_prod <= s1_a * s1_b;
            s2_high <= s1_high;
        end
        // Stage 3, word select
        if (valid_q[1]) begin
            wb_data <= s2_high ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
        end
    end

    assign wb_valid = valid_q[MUL_STAGES-1];
    assign wb_rd    = rd_q[MUL_STAGES-1];

endmodule

// ==== source/register_file.sv ====
////////////////////////////////////////
// Register file
// 32 entries, two issue read ports, one inspection read
// port and one write port per writeback group
////////////////////////////////////////

`timescale 1ns/100ps

module register_file import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Issue read ports
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output data_t     rs1_data,
    output data_t     rs2_data,

    // Writeback group 0, ALU
    input  logic      wb0_valid,
    input  reg_addr_t wb0_rd,
    input  data_t     wb0_data,

    // Writeback group 1, multiplier
    input  logic      wb1_valid,
    input  reg_addr_t wb1_rd,
    input  data_t     wb1_data,

    input  reg_addr_t inspect_addr,
    output data_t     inspect_data
);

    data_t regs [NUM_REGS];

    logic [NUM_REGS-1:0] wb0_hit;
    logic [NUM_REGS-1:0] wb1_hit;

    ////////////////////////////////////////
    // Write decode
    // Entry 0 never matches, so x0 holds its reset value of zero
    always_comb begin
        wb0_hit = '0;
        wb1_hit = '0;
        for (int i = 1; i < NUM_REGS; i++) begin
            wb0_hit[i] = wb0_valid && (wb0_rd == reg_addr_t'(i));
            wb1_hit[i] = wb1_valid && (wb1_rd == reg_addr_t'(i));
        end
    end

    ////////////////////////////////////////
    // Storage
    // Groups never target the same register on one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (wb0_hit[i]) begin
                    regs[i] <= wb0_data;
                end else if (wb1_hit[i]) begin
                    regs[i] <= wb1_data;
                end
            end
        end
    end

    // Combinational reads
    assign rs1_data     = regs[rs1_addr];
    assign rs2_data     = regs[rs2_addr];
    assign inspect_data = regs[inspect_addr];

endmodule

// ==== source/exec_core.sv ====
////////////////////////////////////////
// Execution core
// Issue stage feeding the ALU and the multiplier side by
// side, with both writeback groups into the register file
////////////////////////////////////////

`timescale 1ns/100ps

module exec_core (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        issue_valid,
    input  logic        issue_unit,
    input  logic [3:0]  issue_op,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] issue_imm,
    output logic        issue_ready,

    input  logic [4:0]  inspect_addr,
    output logic [31:0] inspect_data
);

    // Register file read
    logic [4:0]  rf_rs1_addr;
    logic [4:0]  rf_rs2_addr;
    logic [31:0] rf_rs1_data;
    logic [31:0] rf_rs2_data;

    // ALU issue
    logic        alu_start;
    logic [3:0]  alu_op;
    logic [31:0] alu_rs1;
    logic [31:0] alu_rs2;
    logic [31:0] alu_imm;
    logic [4:0]  alu_rd;

    // Multiplier issue
    logic        mul_start;
    logic [3:0]  mul_op;
    logic [31:0] mul_rs1;
    logic [31:0] mul_rs2;
    logic [4:0]  mul_rd;

    // Writeback groups
    logic        alu_wb_valid;
    logic [4:0]  alu_wb_rd;
    logic [31:0] alu_wb_data;
    logic        mul_wb_valid;
    logic [4:0]  mul_wb_rd;
    logic [31:0] mul_wb_data;

    ////////////////////////////////////////
    // Issue
    issue_stage i_issue_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_unit   (issue_unit),
        .issue_op     (issue_op),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .issue_imm    (issue_imm),
        .issue_ready  (issue_ready),
        .rf_rs1_addr  (rf_rs1_addr),
        .rf_rs2_addr  (rf_rs2_addr),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .alu_start    (alu_start),
        .alu_op       (alu_op),
        .alu_rs1      (alu_rs1),
        .alu_rs2      (alu_rs2),
        .alu_imm      (alu_imm),
        .alu_rd       (alu_rd),
        .mul_start    (mul_start),
        .mul_op       (mul_op),
        .mul_rs1      (mul_rs1),
        .mul_rs2      (mul_rs2),
        .mul_rd       (mul_rd),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_rd    (alu_wb_rd),
        .mul_wb_valid (mul_wb_valid),
        .mul_wb_rd    (mul_wb_rd)
    );

    ////////////////////////////////////////
    // Execution units
    alu_unit i_alu_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_start (alu_start),
        .alu_op    (alu_op),
        .alu_rs1   (alu_rs1),
        .alu_rs2   (alu_rs2),
        .alu_imm   (alu_imm),
        .alu_rd    (alu_rd),
        .wb_valid  (alu_wb_valid),
        .wb_rd     (alu_wb_rd),
        .wb_data   (alu_wb_data)
    );

    mul_unit i_mul_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .mul_op    (mul_op),
        .mul_rs1   (mul_rs1),
        .mul_rs2   (mul_rs2),
        .mul_rd    (mul_rd),
        .wb_valid  (mul_wb_valid),
        .wb_rd     (mul_wb_rd),
        .wb_data   (mul_wb_data)
    );

    ////////////////////////////////////////
    // Writeback
    // Group 0 is the ALU, group 1 the multiplier
    register_file i_register_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr     (rf_rs1_addr),
        .rs2_addr     (rf_rs2_addr),
        .rs1_data     (rf_rs1_data),
        .rs2_data     (rf_rs2_data),
        .wb0_valid    (alu_wb_valid),
        .wb0_rd       (alu_wb_rd),
        .wb0_data     (alu_wb_data),
        .wb1_valid    (mul_wb_valid),
        .wb1_rd       (mul_wb_rd),
        .wb1_data     (mul_wb_data),
        .inspect_addr (inspect_addr),
        .inspect_data (inspect_data)
    );

endmodule

// ==== tests/tb_tests.svh ====
////////////////////////////////////////
// Directed tests for the execution core
// Operation drivers, register compare and one task per test
////////////////////////////////////////

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic report_mismatch(input string name, input data_t actual, input data_t expected);
    $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
    errors++;
endtask

// Issue one operation and update the model in program order
task automatic send_op(input unit_t unit, input op_t op, input int rd,
                       input int rs1, input int rs2, input data_t imm);
    data_t expected;
    if (unit == UNIT_ALU) begin
        expected = alu_model(op, model_regs[rs1], model_regs[rs2], imm);
    end else begin
        expected = mul_model(op, model_regs[rs1], model_regs[rs2]);
    end
    if (rd != 0) begin
        model_regs[rd] = expected;
    end
    issue_valid = 1'b1;
    issue_unit  = unit;
    issue_op    = op;
    rd_addr     = reg_addr_t'(rd);
    rs1_addr    = reg_addr_t'(rs1);
    rs2_addr    = reg_addr_t'(rs2);
    issue_imm   = imm;
    last_stalls = 0;
    #1;
    while (!issue_ready) begin
        @(posedge clk);
        #2;
        last_stalls++;
    end
    // Acceptance edge
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
endtask

task automatic load_imm(input int rd, input data_t imm);
    send_op(UNIT_ALU, OP_LI, rd, 0, 0, imm);
endtask

task automatic exec_alu(input op_t op, input int rd, input int rs1, input int rs2);
    send_op(UNIT_ALU, op, rd, rs1, rs2, '0);
endtask

task automatic exec_mul(input op_t op, input int rd, input int rs1, input int rs2);
    send_op(UNIT_MUL, op, rd, rs1, rs2, '0);
endtask

// The last operation keeps its fields, so ready returns once its rd is written
task automatic drain_pipeline();
    #1;
    while (!issue_ready) begin
        @(posedge clk);
        #2;
    end
    repeat (MUL_STAGES) @(posedge clk);
    #1;
endtask

// One register per cycle, address driven after the edge
task automatic compare_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
        inspect_addr = reg_addr_t'(r);
        #2;
        if (inspect_data !== model_regs[r]) begin
            report_mismatch($sformatf("inspect_data[x%0d]", r), inspect_data, model_regs[r]);
        end
        @(posedge clk);
        #1;
    end
endtask

task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) begin
        tests_passed++;
        $display("Test %s finished with no errors", name);
    end else begin
        tests_failed++;
        $display("Test %s finished with %0d errors", name, errors - start_errors);
    end
endtask

////////////////////////////////////////
// Tests
task automatic verify_reset();
    int start_errors;
    start_errors = errors;
    if (issue_ready !== 1'b1) begin
        $display("** Error at %0t: issue_ready = %b, expected 1", $time, issue_ready);
        errors++;
    end
    compare_regs();
    report_test("reset", start_errors);
endtask

task automatic alu_ops();
    int    start_errors;
    int    n;
    data_t edge_vals [8];
    start_errors = errors;
    edge_vals = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001,
                  32'h0000_0025, 32'hffff_ffe3, 32'h0000_0000, 32'h0000_001f};
    // Sign and shift edge values in x1..x8, random values in x9..x15
    for (int r = 1; r <= 8; r++) begin
        load_imm(r, edge_vals[r-1]);
    end
    for (int r = 9; r <= 15; r++) begin
        load_imm(r, $urandom());
    end
    n = 0;
    for (int op = OP_ADD; op <= OP_SLTU; op++) begin
        for (int k = 0; k < 6; k++) begin
            exec_alu(op_t'(op), 16 + n % 16, 1 + $urandom() % 15, 1 + $urandom() % 15);
            n++;
        end
    end
    // Most negative against most positive, -1 against 1
    exec_alu(OP_SLT, 16, 1, 2);
    exec_alu(OP_SLT, 17, 2, 1);
    exec_alu(OP_SLTU, 18, 1, 2);
    exec_alu(OP_SLTU, 19, 2, 1);
    exec_alu(OP_SLT, 20, 3, 4);
    exec_alu(OP_SLT, 21, 4, 3);
    exec_alu(OP_SLTU, 22, 3, 4);
    exec_alu(OP_SLTU, 23, 4, 3);
    // Shift amounts with upper bits set in rs2
    exec_alu(OP_SLL, 24, 1, 5);
    exec_alu(OP_SRL, 25, 1, 5);
    exec_alu(OP_SRA, 26, 1, 5);
    exec_alu(OP_SLL, 27, 3, 6);
    exec_alu(OP_SRL, 28, 3, 6);
    exec_alu(OP_SRA, 29, 2, 6);
    drain_pipeline();
    compare_regs();
    report_test("alu_ops", start_errors);
endtask

task automatic mul_ops();
    int start_errors;
    int n;
    start_errors = errors;
    load_imm(1, 32'h8000_0000);
    load_imm(2, 32'hffff_ffff);
    load_imm(3, 32'h7fff_ffff);
    load_imm(4, 32'h0000_0001);
    for (int r = 5; r <= 8; r++) begin
        load_imm(r, $urandom());
    end
    n = 0;
    // Every pairing of the extreme values
    for (int op = OP_MUL; op <= OP_MULHU; op++) begin
        for (int a = 1; a <= 4; a++) begin
            for (int b = 1; b <= 4; b++) begin
                exec_mul(op_t'(op), 16 + n % 16, a, b);
                n++;
            end
        end
    end
    for (int op = OP_MUL; op <= OP_MULHU; op++) begin
        for (int k = 0; k < 4; k++) begin
            exec_mul(op_t'(op), 16 + n % 16, 5 + $urandom() % 4, 5 + $urandom() % 4);
            n++;
        end
    end
    drain_pipeline();
    compare_regs();
    report_test("mul_ops", start_errors);
endtask

task automatic dependency_chains();
    int start_errors;
    start_errors = errors;
    load_imm(1, $urandom());
    load_imm(2, $urandom());
    // Results feed the next operation through rs1 and through rs2
    exec_mul(OP_MUL, 3, 1, 2);
    exec_alu(OP_ADD, 4, 3, 1);
    exec_mul(OP_MULHU, 5, 3, 4);
    exec_alu(OP_SUB, 6, 4, 5);
    // WAW on x7 with the multiplier first
    exec_mul(OP_MULH, 7, 1, 2);
    exec_alu(OP_XOR, 7, 1, 2);
    exec_mul(OP_MULHSU, 7, 7, 6);
    exec_alu(OP_SLT, 8, 7, 3);
    load_imm(9, 32'd3);
    for (int k = 0; k < 5; k++) begin
        exec_mul(OP_MUL, 9, 9, 1);
        exec_alu(OP_ADD, 9, 9, 2);
    end
    drain_pipeline();
    compare_regs();
    report_test("dependency_chains", start_errors);
endtask

task automatic mul_burst();
    int start_errors;
    start_errors = errors;
    for (int r = 1; r <= 4; r++) begin
        load_imm(r, $urandom());
    end
    drain_pipeline();
    // Independent multiplies issued one per cycle
    for (int k = 0; k < 8; k++) begin
        exec_mul(op_t'(k % 4), 10 + k, 1 + k % 4, 1 + (k + 1) % 4);
        if (last_stalls != 0) begin
            $display("Multiply %0d waited %0d cycles for issue_ready with no dependence",
                     k, last_stalls);
            errors++;
        end
    end
    drain_pipeline();
    compare_regs();
    report_test("mul_burst", start_errors);
endtask

task automatic x0_protection();
    int start_errors;
    start_errors = errors;
    load_imm(1, $urandom() | 32'd1);
    load_imm(2, $urandom() | 32'd1);
    // Both units target x0 back to back
    load_imm(0, 32'hdead_beef);
    exec_mul(OP_MUL, 0, 1, 2);
    exec_alu(OP_ADD, 0, 1, 2);
    // x0 as a source
    exec_alu(OP_ADD, 10, 0, 1);
    exec_mul(OP_MULHU, 11, 0, 2);
    exec_alu(OP_OR, 12, 0, 0);
    drain_pipeline();
    compare_regs();
    report_test("x0_protection", start_errors);
endtask

`endif

// ==== tests/tb_exec_core.sv ====
////////////////////////////////////////
// Execution core testbench
// Clock, reset, register model, watchdog and summary
// around directed tests of the issue and writeback slice
////////////////////////////////////////

`timescale 1ns/100ps

module tb_exec_core import exec_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;
    // Operations issued per test summed over all tests
    localparam int TOTAL_OPS = 89 + 88 + 21 + 12 + 8;
    // Register compare plus drain at the end of each test
    localparam int CHECK_CYCLES = NUM_REGS + 2 * MUL_STAGES + 4;
    localparam int WATCHDOG_CYCLES =
        4 * (TOTAL_OPS * (MUL_STAGES + 2) + NUM_TESTS * CHECK_CYCLES);
    localparam data_t SIGN_BIT = {1'b1, {(XLEN-1){1'b0}}};

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    unit_t     issue_unit;
    op_t       issue_op;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    data_t     issue_imm;
    logic      issue_ready;
    reg_addr_t inspect_addr;
    data_t     inspect_data;

    // Expected register contents in program order
    data_t model_regs [NUM_REGS];
    int    errors;
    int    tests_passed;
    int    tests_failed;
    int    last_stalls;

    exec_core i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_unit   (issue_unit),
        .issue_op     (issue_op),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .issue_imm    (issue_imm),
        .issue_ready  (issue_ready),
        .inspect_addr (inspect_addr),
        .inspect_data (inspect_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    function automatic data_t alu_model(op_t op, data_t a, data_t b, data_t imm);
        logic [SHAMT_W-1:0] sh;
        logic [2*XLEN-1:0]  ext;
        sh  = b[SHAMT_W-1:0];
        // Arithmetic shift as a logical shift of the sign-filled value
        ext = {{XLEN{a[XLEN-1]}}, a} >> sh;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return ext[XLEN-1:0];
            // Flipping the sign bits turns a signed compare into an unsigned one
            OP_SLT:  return data_t'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
            OP_SLTU: return data_t'(a < b);
            OP_LI:   return imm;
            default: return '0;
        endcase
    endfunction

    function automatic data_t mul_model(op_t op, data_t a, data_t b);
        logic [2*XLEN-1:0] a_ext;
        logic [2*XLEN-1:0] b_ext;
        logic [2*XLEN-1:0] prod;
        // Product modulo 2**64 of the extended operands
        a_ext = {{XLEN{a[XLEN-1] && (op != OP_MULHU)}}, a};
        b_ext = {{XLEN{b[XLEN-1] && (op == OP_MUL || op == OP_MULH)}}, b};
        prod  = a_ext * b_ext;
        return (op == OP_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    `include "tb_tests.svh"

    ////////////////////////////////////////
    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t, the tests did not complete in time", $time);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(10402));
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_stalls  = 0;
        issue_valid  = 1'b0;
        issue_unit   = UNIT_ALU;
        issue_op     = OP_ADD;
        rs1_addr     = '0;
        rs2_addr     = '0;
        rd_addr      = '0;
        issue_imm    = '0;
        inspect_addr = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        verify_reset();
        alu_ops();
        mul_ops();
        dependency_chains();
        mul_burst();
        x0_protection();

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+tests
source/exec_pkg.sv
source/issue_stage.sv
source/alu_unit.sv
source/mul_unit.sv
source/register_file.sv
source/exec_core.sv
tests/tb_exec_core.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - files:
      - source/exec_pkg.sv
      - source/issue_stage.sv
      - source/alu_unit.sv
      - source/mul_unit.sv
      - source/register_file.sv
      - source/exec_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_exec_core.sv
